// File: hw/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ==========================================================================
// store path widths and sizes
// ==========================================================================

// byte address width
`define LSU_ADDR_W 32

// store and load data, 32 bit bus
`define LSU_DATA_W 32

// reorder buffer tag
`define LSU_ROB_IDX_W 5

// store queue entries, keep depth a power of two
`define LSU_SQ_DEPTH 8

// slot index width, log2 of the depth
`define LSU_SQ_PTR_W 3

`endif

// File: hw/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

  // ========================================================================
  // vector types
  // ========================================================================

  typedef logic [`LSU_ADDR_W-1:0]    addr_t;
  // data kept right aligned in the low bits
  typedef logic [`LSU_DATA_W-1:0]    data_t;
  typedef logic [`LSU_ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [`LSU_SQ_PTR_W-1:0]  sq_ptr_t;
  // one bit wider than the pointer, holds 0 up to depth
  typedef logic [`LSU_SQ_PTR_W:0]    sq_count_t;
  typedef logic [1:0]                mem_size_t;

  // wishbone side
  typedef logic [`LSU_DATA_W/8-1:0]  wb_sel_t;
  // word address, byte offset bits dropped
  typedef logic [`LSU_ADDR_W-3:0]    wb_adr_t;

  // access size codes
  localparam mem_size_t SIZE_BYTE = 2'd0;
  localparam mem_size_t SIZE_HALF = 2'd1;
  localparam mem_size_t SIZE_WORD = 2'd2;

  // drain FSM
  typedef enum logic [1:0] {
    DRAIN_IDLE,
    DRAIN_BUS,
    DRAIN_DONE
  } drain_state_e;

endpackage

// File: hw/store_queue.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module store_queue (
  input  logic                        clock,
  input  logic                        reset,
  // enqueue in program order
  input  logic                        enq_valid_i,
  input  lsu_pkg::addr_t              enq_addr_i,
  input  lsu_pkg::mem_size_t          enq_size_i,
  input  lsu_pkg::rob_idx_t           enq_rob_idx_i,
  // data fill by tag
  input  logic                        data_valid_i,
  input  lsu_pkg::rob_idx_t           data_rob_idx_i,
  input  lsu_pkg::data_t              data_i,
  // commit from rob
  input  logic                        commit_valid_i,
  input  lsu_pkg::rob_idx_t           commit_rob_idx_i,
  input  logic                        flush_i,
  input  logic                        pop_i,
  output logic                        full_o,
  output lsu_pkg::sq_count_t          free_slots_o,
  // slot view for the forwarding search
  output logic [`LSU_SQ_DEPTH-1:0]    slot_valid_o,
  output logic [`LSU_SQ_DEPTH-1:0]    slot_data_valid_o,
  output lsu_pkg::addr_t              slot_addr_o [`LSU_SQ_DEPTH],
  output lsu_pkg::mem_size_t          slot_size_o [`LSU_SQ_DEPTH],
  output lsu_pkg::data_t              slot_data_o [`LSU_SQ_DEPTH],
  output lsu_pkg::sq_ptr_t            tail_o,
  output lsu_pkg::sq_count_t          count_o,
  // head view for the drain
  output logic                        head_ready_o,
  output lsu_pkg::addr_t              head_addr_o,
  output lsu_pkg::mem_size_t          head_size_o,
  output lsu_pkg::data_t              head_data_o
);

  // ========================================================================
  // state
  // ========================================================================

  // pointers and occupancy
  lsu_pkg::sq_ptr_t   head_q;
  lsu_pkg::sq_ptr_t   tail_q;
  lsu_pkg::sq_count_t count_q;

  // per slot control bits
  logic [`LSU_SQ_DEPTH-1:0] valid_q;
  logic [`LSU_SQ_DEPTH-1:0] data_valid_q;
  logic [`LSU_SQ_DEPTH-1:0] committed_q;

  // per slot payload
  lsu_pkg::addr_t     addr_q [`LSU_SQ_DEPTH];
  lsu_pkg::mem_size_t size_q [`LSU_SQ_DEPTH];
  lsu_pkg::rob_idx_t  rob_q  [`LSU_SQ_DEPTH];
  lsu_pkg::data_t     data_q [`LSU_SQ_DEPTH];

  // next state helpers
  logic                     do_enq;
  logic [`LSU_SQ_DEPTH-1:0] fill_hit;
  logic [`LSU_SQ_DEPTH-1:0] committed_nxt;
  logic [`LSU_SQ_DEPTH-1:0] pop_mask;
  logic [`LSU_SQ_DEPTH-1:0] enq_mask;
  lsu_pkg::sq_count_t       n_commit;

  assign full_o       = (count_q == lsu_pkg::sq_count_t'(`LSU_SQ_DEPTH));
  assign free_slots_o = lsu_pkg::sq_count_t'(`LSU_SQ_DEPTH) - count_q;

  // flush wins over enqueue
  assign do_enq = enq_valid_i && !full_o && !flush_i;

  // ========================================================================
  // tag search, commit prefix
  // ========================================================================

  always_comb begin
    fill_hit      = '0;
    committed_nxt = committed_q;
    pop_mask      = '0;
    enq_mask      = '0;
    n_commit      = '0;
    for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
      // fill only lands on live entries
      fill_hit[i] = data_valid_i && valid_q[i] && (rob_q[i] == data_rob_idx_i);
      // commit needs data already present
      if (commit_valid_i && valid_q[i] && data_valid_q[i] &&
          (rob_q[i] == commit_rob_idx_i)) begin
        committed_nxt[i] = 1'b1;
      end
    end
    // committed slots are a prefix from head, so a plain count gives its length
    for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
      if (valid_q[i] && committed_nxt[i]) begin
        n_commit = n_commit + 1'b1;
      end
    end
    pop_mask[head_q] = pop_i;
    enq_mask[tail_q] = do_enq;
  end

  // ========================================================================
  // control registers
  // ========================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q       <= '0;
      tail_q       <= '0;
      count_q      <= '0;
      valid_q      <= '0;
      data_valid_q <= '0;
      committed_q  <= '0;
    end else begin
      // new slot starts empty, popped slot is freed
      data_valid_q <= (data_valid_q | fill_hit) & ~pop_mask & ~enq_mask;
      committed_q  <= committed_nxt & ~pop_mask & ~enq_mask;
      if (pop_i) begin
        head_q <= head_q + 1'b1;
      end
      if (flush_i) begin
        // tail lands just past the committed prefix, head unchanged by flush
        tail_q  <= head_q + lsu_pkg::sq_ptr_t'(n_commit);
        count_q <= n_commit - lsu_pkg::sq_count_t'(pop_i);
        valid_q <= valid_q & committed_nxt & ~pop_mask;
      end else begin
        if (do_enq) begin
          tail_q <= tail_q + 1'b1;
        end
        count_q <= count_q + lsu_pkg::sq_count_t'(do_enq) - lsu_pkg::sq_count_t'(pop_i);
        valid_q <= (valid_q & ~pop_mask) | enq_mask;
      end
    end
  end

  // payload writes
  always_ff @(posedge clock) begin
    if (do_enq) begin
      addr_q[tail_q] <= enq_addr_i;
      size_q[tail_q] <= enq_size_i;
      rob_q[tail_q]  <= enq_rob_idx_i;
    end
    for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
      if (fill_hit[i]) begin
        data_q[i] <= data_i;
      end
    end
  end

  // ========================================================================
  // outputs
  // ========================================================================

  assign slot_valid_o      = valid_q;
  assign slot_data_valid_o = data_valid_q;
  assign slot_addr_o       = addr_q;
  assign slot_size_o       = size_q;
  assign slot_data_o       = data_q;
  assign tail_o            = tail_q;
  assign count_o           = count_q;

  // head may leave only when retired with data
  assign head_ready_o = valid_q[head_q] && committed_q[head_q] && data_valid_q[head_q];
  assign head_addr_o  = addr_q[head_q];
  assign head_size_o  = size_q[head_q];
  assign head_data_o  = data_q[head_q];

  // core must hold back enqueues once full
  a_no_enq_full : assert property (@(posedge clock) disable iff (reset)
    full_o |-> !enq_valid_i);

  // drain pops only a ready head
  a_pop_ready : assert property (@(posedge clock) disable iff (reset)
    pop_i |-> head_ready_o);

  // natural alignment of every accepted store
  a_enq_aligned : assert property (@(posedge clock) disable iff (reset)
    do_enq |-> ((enq_size_i == lsu_pkg::SIZE_BYTE) ||
                (enq_size_i == lsu_pkg::SIZE_HALF && enq_addr_i[0] == 1'b0) ||
                (enq_size_i == lsu_pkg::SIZE_WORD && enq_addr_i[1:0] == 2'b00)));

endmodule

// File: hw/store_forward.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module store_forward (
  input  logic                        clock,
  input  logic                        reset,
  // load query
  input  logic                        load_valid_i,
  input  lsu_pkg::addr_t              load_addr_i,
  input  lsu_pkg::mem_size_t          load_size_i,
  // queue view
  input  logic [`LSU_SQ_DEPTH-1:0]    slot_valid_i,
  input  logic [`LSU_SQ_DEPTH-1:0]    slot_data_valid_i,
  input  lsu_pkg::addr_t              slot_addr_i [`LSU_SQ_DEPTH],
  input  lsu_pkg::mem_size_t          slot_size_i [`LSU_SQ_DEPTH],
  input  lsu_pkg::data_t              slot_data_i [`LSU_SQ_DEPTH],
  input  lsu_pkg::sq_ptr_t            tail_i,
  input  lsu_pkg::sq_count_t          count_i,
  // registered answer
  output logic                        load_resp_valid_o,
  output logic                        fwd_hit_o,
  output logic                        fwd_pending_o,
  output lsu_pkg::data_t              fwd_data_o
);

  // last byte offset of an access (0, 1 or 3)
  function automatic lsu_pkg::addr_t last_off(input lsu_pkg::mem_size_t size);
    case (size)
      lsu_pkg::SIZE_BYTE: last_off = 32'd0;
      lsu_pkg::SIZE_HALF: last_off = 32'd1;
      default:            last_off = 32'd3;
    endcase
  endfunction

  // keep only the loaded bytes
  function automatic lsu_pkg::data_t size_mask(input lsu_pkg::mem_size_t size);
    case (size)
      lsu_pkg::SIZE_BYTE: size_mask = 32'h0000_00ff;
      lsu_pkg::SIZE_HALF: size_mask = 32'h0000_ffff;
      default:            size_mask = 32'hffff_ffff;
    endcase
  endfunction

  logic           hit_c;
  logic           pend_c;
  lsu_pkg::data_t data_c;

  // ========================================================================
  // youngest first search
  // ========================================================================

  always_comb begin
    logic             found;
    lsu_pkg::sq_ptr_t idx;
    lsu_pkg::addr_t   ld_end;
    lsu_pkg::addr_t   st_end;
    lsu_pkg::addr_t   diff;
    found  = 1'b0;
    hit_c  = 1'b0;
    pend_c = 1'b0;
    data_c = '0;
    idx    = '0;
    diff   = '0;
    st_end = '0;
    // aligned accesses never wrap past the top of memory
    ld_end = load_addr_i + last_off(load_size_i);
    for (int k = 0; k < `LSU_SQ_DEPTH; k++) begin
      // tail minus one is the youngest and the pointer wraps by width
      idx    = tail_i - lsu_pkg::sq_ptr_t'(k + 1);
      st_end = slot_addr_i[idx] + last_off(slot_size_i[idx]);
      if (!found && (k < int'(count_i)) && slot_valid_i[idx] &&
          !(st_end < load_addr_i || ld_end < slot_addr_i[idx])) begin
        found = 1'b1;
        // full cover with data ready forwards and anything else waits
        if (slot_data_valid_i[idx] && slot_addr_i[idx] <= load_addr_i &&
            ld_end <= st_end) begin
          hit_c  = 1'b1;
          diff   = load_addr_i - slot_addr_i[idx];
          data_c = (slot_data_i[idx] >> {diff[1:0], 3'b000}) & size_mask(load_size_i);
        end else begin
          pend_c = 1'b1;
        end
      end
    end
  end

  // ========================================================================
  // response register
  // ========================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      load_resp_valid_o <= 1'b0;
      fwd_hit_o         <= 1'b0;
      fwd_pending_o     <= 1'b0;
    end else begin
      load_resp_valid_o <= load_valid_i;
      if (load_valid_i) begin
        fwd_hit_o     <= hit_c;
        fwd_pending_o <= pend_c;
      end
    end
  end

  // miss leaves data at zero
  always_ff @(posedge clock) begin
    if (load_valid_i) begin
      fwd_data_o <= data_c;
    end
  end

  // search window of count entries behind tail must hold every valid slot
  a_count_matches_valid : assert property (@(posedge clock) disable iff (reset)
    $countones(slot_valid_i) == int'(count_i));

endmodule

// File: hw/store_drain_wb.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module store_drain_wb (
  input  logic                 clock,
  input  logic                 reset,
  // head of the store queue
  input  logic                 head_ready_i,
  input  lsu_pkg::addr_t       head_addr_i,
  input  lsu_pkg::mem_size_t   head_size_i,
  input  lsu_pkg::data_t       head_data_i,
  output logic                 pop_o,
  // wishbone classic master
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output lsu_pkg::wb_adr_t     wb_adr_o,
  output lsu_pkg::wb_sel_t     wb_sel_o,
  output lsu_pkg::data_t       wb_dat_o,
  input  logic                 wb_ack_i
);

  lsu_pkg::drain_state_e state_q;
  lsu_pkg::drain_state_e state_d;

  // latched bus payload
  lsu_pkg::wb_adr_t adr_q;
  lsu_pkg::wb_sel_t sel_q;
  lsu_pkg::data_t   dat_q;

  // lane placement of the head store
  lsu_pkg::wb_sel_t sel_base;
  lsu_pkg::wb_sel_t sel_c;
  lsu_pkg::data_t   dat_c;

  always_comb begin
    case (head_size_i)
      lsu_pkg::SIZE_BYTE: sel_base = 4'b0001;
      lsu_pkg::SIZE_HALF: sel_base = 4'b0011;
      default:            sel_base = 4'b1111;
    endcase
    sel_c = sel_base << head_addr_i[1:0];
    dat_c = head_data_i << {head_addr_i[1:0], 3'b000};
  end

  // ========================================================================
  // FSM
  // ========================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::DRAIN_IDLE: if (head_ready_i) state_d = lsu_pkg::DRAIN_BUS;
      lsu_pkg::DRAIN_BUS:  if (wb_ack_i) state_d = lsu_pkg::DRAIN_DONE;
      // one dead cycle so the queue head settles
      default:             state_d = lsu_pkg::DRAIN_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= lsu_pkg::DRAIN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // capture on the way into DRAIN_BUS
  always_ff @(posedge clock) begin
    if (state_q == lsu_pkg::DRAIN_IDLE && head_ready_i) begin
      adr_q <= head_addr_i[`LSU_ADDR_W-1:2];
      sel_q <= sel_c;
      dat_q <= dat_c;
    end
  end

  // write only master drives cyc and stb together
  assign wb_cyc_o = (state_q == lsu_pkg::DRAIN_BUS);
  assign wb_stb_o = (state_q == lsu_pkg::DRAIN_BUS);
  assign wb_we_o  = (state_q == lsu_pkg::DRAIN_BUS);
  assign wb_adr_o = adr_q;
  assign wb_sel_o = sel_q;
  assign wb_dat_o = dat_q;

  // head leaves the queue in the ack cycle
  assign pop_o = (state_q == lsu_pkg::DRAIN_BUS) && wb_ack_i;

  // cycle drops on the clock after ack
  a_cyc_end : assert property (@(posedge clock) disable iff (reset)
    (wb_stb_o && wb_ack_i) |=> !wb_cyc_o);

  a_stb_hold : assert property (@(posedge clock) disable iff (reset)
    (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) &&
                                 $stable(wb_sel_o) && $stable(wb_dat_o)));

endmodule

// File: hw/store_unit_top.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module store_unit_top (
  input  logic                 clock,
  input  logic                 reset,
  // core side
  input  logic                 enq_valid_i,
  input  lsu_pkg::addr_t       enq_addr_i,
  input  lsu_pkg::mem_size_t   enq_size_i,
  input  lsu_pkg::rob_idx_t    enq_rob_idx_i,
  input  logic                 data_valid_i,
  input  lsu_pkg::rob_idx_t    data_rob_idx_i,
  input  lsu_pkg::data_t       data_i,
  input  logic                 commit_valid_i,
  input  lsu_pkg::rob_idx_t    commit_rob_idx_i,
  input  logic                 flush_i,
  output logic                 full_o,
  output lsu_pkg::sq_count_t   free_slots_o,
  // load query
  input  logic                 load_valid_i,
  input  lsu_pkg::addr_t       load_addr_i,
  input  lsu_pkg::mem_size_t   load_size_i,
  output logic                 load_resp_valid_o,
  output logic                 fwd_hit_o,
  output logic                 fwd_pending_o,
  output lsu_pkg::data_t       fwd_data_o,
  // wishbone
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output lsu_pkg::wb_adr_t     wb_adr_o,
  output lsu_pkg::wb_sel_t     wb_sel_o,
  output lsu_pkg::data_t       wb_dat_o,
  input  logic                 wb_ack_i
);

  // queue to forwarding
  logic [`LSU_SQ_DEPTH-1:0] slot_valid;
  logic [`LSU_SQ_DEPTH-1:0] slot_data_valid;
  lsu_pkg::addr_t           slot_addr [`LSU_SQ_DEPTH];
  lsu_pkg::mem_size_t       slot_size [`LSU_SQ_DEPTH];
  lsu_pkg::data_t           slot_data [`LSU_SQ_DEPTH];
  lsu_pkg::sq_ptr_t         tail;
  lsu_pkg::sq_count_t       count;

  // queue to drain
  logic                     head_ready;
  lsu_pkg::addr_t           head_addr;
  lsu_pkg::mem_size_t       head_size;
  lsu_pkg::data_t           head_data;
  logic                     pop;

  store_queue u_queue (
    .clock, .reset,
    .enq_valid_i, .enq_addr_i, .enq_size_i, .enq_rob_idx_i,
    .data_valid_i, .data_rob_idx_i, .data_i,
    .commit_valid_i, .commit_rob_idx_i,
    .flush_i, .pop_i(pop),
    .full_o, .free_slots_o,
    .slot_valid_o(slot_valid), .slot_data_valid_o(slot_data_valid),
    .slot_addr_o(slot_addr), .slot_size_o(slot_size), .slot_data_o(slot_data),
    .tail_o(tail), .count_o(count),
    .head_ready_o(head_ready), .head_addr_o(head_addr),
    .head_size_o(head_size), .head_data_o(head_data)
  );

  store_forward u_forward (
    .clock, .reset,
    .load_valid_i, .load_addr_i, .load_size_i,
    .slot_valid_i(slot_valid), .slot_data_valid_i(slot_data_valid),
    .slot_addr_i(slot_addr), .slot_size_i(slot_size), .slot_data_i(slot_data),
    .tail_i(tail), .count_i(count),
    .load_resp_valid_o, .fwd_hit_o, .fwd_pending_o, .fwd_data_o
  );

  store_drain_wb u_drain (
    .clock, .reset,
    .head_ready_i(head_ready), .head_addr_i(head_addr),
    .head_size_i(head_size), .head_data_i(head_data),
    .pop_o(pop),
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o,
    .wb_ack_i
  );

endmodule

// File: test/store_unit_tb.sv
`timescale 1ns/100ps

module store_unit_tb;

  localparam string STIM_FILE = "test/store_unit_stim.txt";
  // watchdog budget per stimulus line
  localparam int CYCLES_PER_LINE = 40;

  logic                clock;
  logic                reset;
  logic                enq_valid_i;
  lsu_pkg::addr_t      enq_addr_i;
  lsu_pkg::mem_size_t  enq_size_i;
  lsu_pkg::rob_idx_t   enq_rob_idx_i;
  logic                data_valid_i;
  lsu_pkg::rob_idx_t   data_rob_idx_i;
  lsu_pkg::data_t      data_i;
  logic                commit_valid_i;
  lsu_pkg::rob_idx_t   commit_rob_idx_i;
  logic                flush_i;
  logic                full_o;
  lsu_pkg::sq_count_t  free_slots_o;
  logic                load_valid_i;
  lsu_pkg::addr_t      load_addr_i;
  lsu_pkg::mem_size_t  load_size_i;
  logic                load_resp_valid_o;
  logic                fwd_hit_o;
  logic                fwd_pending_o;
  lsu_pkg::data_t      fwd_data_o;
  logic                wb_cyc_o;
  logic                wb_stb_o;
  logic                wb_we_o;
  lsu_pkg::wb_adr_t    wb_adr_o;
  lsu_pkg::wb_sel_t    wb_sel_o;
  lsu_pkg::data_t      wb_dat_o;
  logic                wb_ack_i;

  // expected bus writes, oldest first
  lsu_pkg::wb_adr_t exp_adr [$];
  lsu_pkg::wb_sel_t exp_sel [$];
  lsu_pkg::data_t   exp_dat [$];

  // pending load answer, checked one cycle after the query
  logic           load_check;
  logic           exp_hit;
  logic           exp_pend;
  lsu_pkg::data_t exp_ldata;

  int          test_errs;
  int          total_errs;
  int          ok_tests;
  int          fail_tests;
  int          watch_cycles;
  logic [31:0] rng_state;
  int          ack_wait;
  logic        slave_busy;

  store_unit_top UUT (.*);

  always #10 clock = ~clock;

  // ==========================================================================
  // compare tasks
  // ==========================================================================

  task automatic check_addr(input string name, input lsu_pkg::wb_adr_t got,
                            input lsu_pkg::wb_adr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_sel(input string name, input lsu_pkg::wb_sel_t got,
                           input lsu_pkg::wb_sel_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_data(input string name, input lsu_pkg::data_t got,
                            input lsu_pkg::data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %0s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_count(input string name, input lsu_pkg::sq_count_t got,
                             input lsu_pkg::sq_count_t exp);
    if (got !== exp) begin
      $display("MISMATCH %0s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  // 32 bit xorshift step
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ==========================================================================
  // wishbone slave model
  // ==========================================================================

  // compare one accepted write against the oldest expected one
  task automatic accept_write();
    if (exp_adr.size() == 0) begin
      $display("unexpected bus write to word address %h", wb_adr_o);
      test_errs++;
    end else begin
      check_flag("wb_we_o", wb_we_o, 1'b1);
      check_addr("wb_adr_o", wb_adr_o, exp_adr.pop_front());
      check_sel("wb_sel_o", wb_sel_o, exp_sel.pop_front());
      check_data("wb_dat_o", wb_dat_o, exp_dat.pop_front());
    end
  endtask

  initial begin
    wb_ack_i   = 1'b0;
    slave_busy = 1'b0;
    ack_wait   = 0;
    forever begin
      @(posedge clock);
      #2;
      // ack is a single cycle pulse
      if (wb_ack_i) begin
        wb_ack_i = 1'b0;
      end else if (!reset && wb_cyc_o && wb_stb_o) begin
        // new strobe, draw 0 to 3 wait cycles
        if (!slave_busy) begin
          slave_busy = 1'b1;
          rng_state  = xorshift(rng_state);
          ack_wait   = int'(rng_state % 32'd4);
        end
        if (ack_wait == 0) begin
          accept_write();
          wb_ack_i   = 1'b1;
          slave_busy = 1'b0;
        end else begin
          ack_wait--;
        end
      end
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  // one clock, load answer sampled just after the edge
  task automatic step_cycle();
    @(posedge clock);
    #1;
    if (load_check) begin
      check_flag("load_resp_valid_o", load_resp_valid_o, 1'b1);
      check_flag("fwd_hit_o", fwd_hit_o, exp_hit);
      check_flag("fwd_pending_o", fwd_pending_o, exp_pend);
      // data only defined for hit and miss
      if (!exp_pend) begin
        check_data("fwd_data_o", fwd_data_o, exp_ldata);
      end
      load_check = 1'b0;
    end
    #1;
    enq_valid_i    = 1'b0;
    data_valid_i   = 1'b0;
    commit_valid_i = 1'b0;
    flush_i        = 1'b0;
    load_valid_i   = 1'b0;
  endtask

  // all expected writes seen and bus back to idle
  task automatic wait_drained();
    while (exp_adr.size() != 0 || wb_cyc_o) begin
      step_cycle();
    end
  endtask

  task automatic run_commands(input int fd);
    int                 r;
    int                 n;
    logic [7:0]         cmd;
    logic [8*128-1:0]   line_buf;
    logic [8*24-1:0]    tname;
    lsu_pkg::addr_t     a;
    lsu_pkg::mem_size_t sz;
    lsu_pkg::rob_idx_t  tg;
    lsu_pkg::data_t     d;
    lsu_pkg::wb_adr_t   wa;
    lsu_pkg::wb_sel_t   ws;
    lsu_pkg::sq_count_t fr;
    logic               fl;
    r = $fscanf(fd, " %s", cmd);
    while (r == 1) begin
      case (cmd)
        "#": r = $fgets(line_buf, fd);
        "E": begin
          r = $fscanf(fd, "%h %h %h", a, sz, tg);
          enq_valid_i   = 1'b1;
          enq_addr_i    = a;
          enq_size_i    = sz;
          enq_rob_idx_i = tg;
          step_cycle();
        end
        "D": begin
          r = $fscanf(fd, "%h %h", tg, d);
          data_valid_i   = 1'b1;
          data_rob_idx_i = tg;
          data_i         = d;
          step_cycle();
        end
        "C": begin
          r = $fscanf(fd, "%h", tg);
          commit_valid_i   = 1'b1;
          commit_rob_idx_i = tg;
          step_cycle();
        end
        "F": begin
          flush_i = 1'b1;
          step_cycle();
        end
        "L": begin
          r = $fscanf(fd, "%h %h %h %h %h", a, sz, exp_hit, exp_pend, exp_ldata);
          load_valid_i = 1'b1;
          load_addr_i  = a;
          load_size_i  = sz;
          load_check   = 1'b1;
          step_cycle();
        end
        "W": begin
          r = $fscanf(fd, "%h %h %h", wa, ws, d);
          exp_adr.push_back(wa);
          exp_sel.push_back(ws);
          exp_dat.push_back(d);
        end
        "S": begin
          r = $fscanf(fd, "%h %h", fr, fl);
          check_count("free_slots_o", free_slots_o, fr);
          check_flag("full_o", full_o, fl);
        end
        "I": begin
          r = $fscanf(fd, "%d", n);
          repeat (n) step_cycle();
        end
        "A": wait_drained();
        "T": begin
          r = $fscanf(fd, "%s", tname);
          wait_drained();
          if (test_errs == 0) begin
            $display("[%0s] ok", tname);
            ok_tests++;
          end else begin
            $display("[%0s] failing with %0d errors", tname, test_errs);
            fail_tests++;
          end
          total_errs += test_errs;
          test_errs = 0;
        end
        default: begin
          $display("unknown command %s in stimulus file", cmd);
          test_errs++;
        end
      endcase
      r = $fscanf(fd, " %s", cmd);
    end
  endtask

  // ==========================================================================
  // main sequence and watchdog
  // ==========================================================================

  initial begin
    int               fd;
    int               n_lines;
    logic [8*128-1:0] line_buf;
    clock            = 1'b0;
    reset            = 1'b1;
    enq_valid_i      = 1'b0;
    enq_addr_i       = '0;
    enq_size_i       = '0;
    enq_rob_idx_i    = '0;
    data_valid_i     = 1'b0;
    data_rob_idx_i   = '0;
    data_i           = '0;
    commit_valid_i   = 1'b0;
    commit_rob_idx_i = '0;
    flush_i          = 1'b0;
    load_valid_i     = 1'b0;
    load_addr_i      = '0;
    load_size_i      = '0;
    load_check       = 1'b0;
    exp_hit          = 1'b0;
    exp_pend         = 1'b0;
    exp_ldata        = '0;
    test_errs        = 0;
    total_errs       = 0;
    ok_tests         = 0;
    fail_tests       = 0;
    rng_state        = 32'd97;
    n_lines          = 0;
    // size the watchdog from the stimulus length
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line_buf, fd) != 0) begin
        n_lines++;
      end
      $fclose(fd);
      fd = $fopen(STIM_FILE, "r");
    end
    watch_cycles = (n_lines + 1) * CYCLES_PER_LINE;
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;
    // reset values of bus control and load answer
    check_flag("wb_cyc_o", wb_cyc_o, 1'b0);
    check_flag("wb_stb_o", wb_stb_o, 1'b0);
    check_flag("wb_we_o", wb_we_o, 1'b0);
    check_flag("full_o", full_o, 1'b0);
    check_flag("load_resp_valid_o", load_resp_valid_o, 1'b0);
    check_flag("fwd_hit_o", fwd_hit_o, 1'b0);
    check_flag("fwd_pending_o", fwd_pending_o, 1'b0);
    if (fd == 0) begin
      $display("cannot open stimulus file %0s", STIM_FILE);
      test_errs++;
    end else begin
      run_commands(fd);
      $fclose(fd);
    end
    total_errs += test_errs;
    $display("summary: %0d tests ok, %0d tests failing, %0d errors",
             ok_tests, fail_tests, total_errs);
    if (fail_tests == 0 && total_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (watch_cycles != 0);
    repeat (watch_cycles) @(posedge clock);
    $display("simulation timed out after %0d cycles", watch_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

// File: test/store_unit_stim.txt
# one command per line, numbers in hex: E addr size tag | D tag data | C tag | F
# L addr size hit pend data | W wb_adr sel dat | S free full | I cycles | A | T name
S 8 0
L 00000100 2 0 0 00000000
T reset
W 00000400 2 0000a500
W 00000401 c beef0000
W 00000800 f 12345678
E 00001001 0 01
E 00001006 1 02
E 00002000 2 03
D 03 12345678
D 01 000000a5
D 02 0000beef
C 02
C 01
C 03
T drain_order
E 00003000 2 04
D 04 aabbccdd
E 00003002 1 05
D 05 00001122
E 00003010 2 06
L 00003000 0 1 0 000000dd
L 00003002 1 1 0 00001122
L 00003003 0 1 0 00000011
L 00003000 2 0 1 00000000
L 00003011 0 0 1 00000000
L 00004000 2 0 0 00000000
D 06 01020304
L 00003012 1 1 0 00000102
W 00000c00 f aabbccdd
W 00000c00 c 11220000
W 00000c04 f 01020304
C 04
C 05
C 06
T forwarding
E 00005004 2 07
C 07
I 4
S 7 0
D 07 cafef00d
W 00001401 f cafef00d
C 07
T commit_needs_data
E 00006000 2 08
E 00006004 2 09
D 08 11111111
D 09 22222222
E 00006008 2 0a
E 0000600c 2 0b
E 00006010 0 0c
D 0a 33333333
W 00001800 f 11111111
W 00001801 f 22222222
C 08
C 09
F
L 00006008 2 0 0 00000000
T flush
E 00007000 2 10
E 00007004 2 11
E 00007008 2 12
E 0000700c 2 13
E 00007010 2 14
E 00007014 2 15
E 00007018 2 16
E 0000701c 2 17
S 0 1
W 00001c00 f 5a5a5a50
W 00001c01 f 5a5a5a51
W 00001c02 f 5a5a5a52
W 00001c03 f 5a5a5a53
W 00001c04 f 5a5a5a54
W 00001c05 f 5a5a5a55
W 00001c06 f 5a5a5a56
W 00001c07 f 5a5a5a57
D 10 5a5a5a50
D 11 5a5a5a51
D 12 5a5a5a52
D 13 5a5a5a53
D 14 5a5a5a54
D 15 5a5a5a55
D 16 5a5a5a56
D 17 5a5a5a57
C 10
C 11
C 12
C 13
C 14
C 15
C 16
C 17
A
S 8 0
T full

// File: build.f
+incdir+hw
hw/lsu_pkg.sv
hw/store_queue.sv
hw/store_forward.sv
hw/store_drain_wb.sv
hw/store_unit_top.sv
test/store_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module store_unit_tb \
  -f build.f \
  -o store_unit_sim

# the testbench always ends the run, the log decides the result
./obj_dir/store_unit_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi
